// File: src/lsu_pkg.sv
package lsu_pkg;

  // major opcodes of the base integer set
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // access size as coded in funct3[1:0]
  typedef enum logic [1:0] {
    BYTE = 2'b00,
    HALF = 2'b01,
    WORD = 2'b10
  } size_e;

  //////////////////////////////////////////////////////////////////////
  // instruction word views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [11:0] imm;       // offset for loads
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0]  imm_hi;    // offset bits 11..5
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  imm_lo;    // offset bits 4..0
    logic [6:0]  opcode;
  } stype_t;

  // same 32 bits, read as load or as store
  typedef union packed {
    itype_t itype;
    stype_t stype;
  } instr_u;

  //////////////////////////////////////////////////////////////////////
  // decoded op, load context and result
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        we;        // store
    size_e       size;
    logic        sign_ext;
    logic [31:0] imm;       // already sign extended
    logic [4:0]  rd;
  } lsu_op_t;

  // follows each granted load part over to the result stage
  typedef struct packed {
    size_e       size;
    logic        sign_ext;
    logic [1:0]  offset;      // byte offset of the access
    logic [4:0]  rd;
    logic        second_part; // upper word of a split access
    logic        last;        // this part completes the load
  } ld_ctx_t;

  typedef struct packed {
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
  } lsu_res_t;

endpackage

// File: src/dbus_pkg.sv
package dbus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int BE_W   = DATA_W / 8;  // one enable per byte lane

  //////////////////////////////////////////////////////////////////////
  // req/gnt/rvalid data bus
  //////////////////////////////////////////////////////////////////////

  // master to memory
  typedef struct packed {
    logic              req;
    logic              we;
    logic [BE_W-1:0]   be;
    logic [ADDR_W-1:0] addr;    // word aligned
    logic [DATA_W-1:0] wdata;   // already placed on its byte lanes
  } dbus_req_t;

  // memory to master
  typedef struct packed {
    logic              gnt;     // request taken at this edge
    logic              rvalid;  // one per grant, loads and stores
    logic [DATA_W-1:0] rdata;
  } dbus_rsp_t;

endpackage

// File: src/lsu_decode.sv
`timescale 1ns/1ns

module lsu_decode
(
  input  lsu_pkg::instr_u  instr_i,
  output lsu_pkg::lsu_op_t op_o,
  output logic             is_mem_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       is_load;
  logic       is_store;
  logic       load_ok;
  logic       store_ok;

  // opcode and funct3 sit at the same place in both views
  assign opcode   = instr_i.itype.opcode;
  assign funct3   = instr_i.itype.funct3;

  assign is_load  = (opcode == lsu_pkg::OPC_LOAD);
  assign is_store = (opcode == lsu_pkg::OPC_STORE);

  // lb lh lw lbu lhu
  assign load_ok  = is_load && (funct3 != 3'd3) && (funct3 != 3'd6) && (funct3 != 3'd7);
  // sb sh sw only, no unsigned stores
  assign store_ok = is_store && !funct3[2] && (funct3 != 3'd3);

  assign is_mem_o = load_ok || store_ok;

  always_comb
  begin
    op_o.we       = is_store;
    op_o.size     = lsu_pkg::size_e'(funct3[1:0]);
    op_o.sign_ext = ~funct3[2];             // bit 2 set means unsigned

    if (is_store)
    begin
      // s-type splits the offset around rs2
      op_o.imm = {{20{instr_i.stype.imm_hi[6]}}, instr_i.stype.imm_hi, instr_i.stype.imm_lo};
      op_o.rd  = '0;                        // no destination register
    end
    else
    begin
      op_o.imm = {{20{instr_i.itype.imm[11]}}, instr_i.itype.imm};
      op_o.rd  = instr_i.itype.rd;
    end
  end

endmodule

// File: src/lsu_execute.sv
`timescale 1ns/1ns

module lsu_execute
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  logic                is_mem_i,
  input  lsu_pkg::lsu_op_t    op_i,
  input  logic [31:0]         rs1_i,
  input  logic [31:0]         rs2_i,
  input  dbus_pkg::dbus_rsp_t dbus_i,
  output dbus_pkg::dbus_req_t dbus_o,
  output logic                ready_o,
  output logic                illegal_o,
  output lsu_pkg::ld_ctx_t    ld_ctx_o,
  output logic                ld_grant_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_RV} state_e;

  state_e                        state_q, state_d;
  logic                          accept;
  logic [dbus_pkg::ADDR_W-1:0]   addr_sum;
  logic                          split_d;
  logic [dbus_pkg::ADDR_W-1:0]   addr_q;
  lsu_pkg::lsu_op_t              op_q;
  logic [dbus_pkg::DATA_W-1:0]   wdata_q;
  logic                          split_q;   // two bus transactions needed
  logic                          part_q;    // working on the second one
  logic [1:0]                    offset;
  logic [dbus_pkg::ADDR_W-3:0]   word_addr;
  logic [dbus_pkg::BE_W-1:0]     be;
  logic [dbus_pkg::DATA_W-1:0]   wdata_rot;
  logic                          bus_req;

  assign ready_o   = (state_q == IDLE);
  assign accept    = valid_i && ready_o && is_mem_i;
  assign illegal_o = valid_i && ready_o && !is_mem_i;  // no bus access follows

  // address from the register operand and the immediate
  assign addr_sum  = rs1_i + op_i.imm;
  assign split_d   = ((op_i.size == lsu_pkg::WORD) && (addr_sum[1:0] != 2'b00)) ||
                     ((op_i.size == lsu_pkg::HALF) && (addr_sum[1:0] == 2'b11));

  ////////////////////////////////////////////////////////////////////
  // state and operand registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= IDLE;
      split_q <= 1'b0;
      part_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (accept)
      begin
        split_q <= split_d;
        part_q  <= 1'b0;
      end
      else if ((state_q == WAIT_RV) && dbus_i.rvalid && split_q)
        part_q <= 1'b1;                     // on to the next word
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q  <= addr_sum;
      op_q    <= op_i;
      wdata_q <= rs2_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // byte enables and write data
  ////////////////////////////////////////////////////////////////////

  assign offset    = addr_q[1:0];
  assign word_addr = addr_q[dbus_pkg::ADDR_W-1:2] + (dbus_pkg::ADDR_W-2)'(part_q);

  always_comb
  begin
    case (op_q.size)
      lsu_pkg::WORD:
      begin
        if (!part_q)
          be = 4'b1111 << offset;           // 1111 1110 1100 1000
        else
          be = ~(4'b1111 << offset);        // remaining low lanes
      end
      lsu_pkg::HALF:
      begin
        if (!part_q)
          be = 4'b0011 << offset;           // top lane only at offset 3
        else
          be = 4'b0001;                     // spill byte of the split half
      end
      lsu_pkg::BYTE: be = 4'b0001 << offset;
      default:       be = '0;
    endcase
  end

  // rotate left by the offset, the second part reuses the same lanes
  always_comb
  begin
    case (offset)
      2'b00: wdata_rot = wdata_q;
      2'b01: wdata_rot = {wdata_q[23:0], wdata_q[31:24]};
      2'b10: wdata_rot = {wdata_q[15:0], wdata_q[31:16]};
      2'b11: wdata_rot = {wdata_q[7:0],  wdata_q[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // bus FSM
  ////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state_q;
    bus_req = 1'b0;
    case (state_q)
      IDLE:
      begin
        if (accept)
          state_d = REQ;                    // req rises next cycle
      end
      REQ:
      begin
        bus_req = 1'b1;
        if (dbus_i.gnt)
          state_d = WAIT_RV;
      end
      WAIT_RV:
      begin
        if (dbus_i.rvalid)
          state_d = (split_q && !part_q) ? REQ : IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb
  begin
    dbus_o.req   = bus_req;
    dbus_o.we    = op_q.we;
    dbus_o.be    = be;
    dbus_o.addr  = {word_addr, 2'b00};
    dbus_o.wdata = wdata_rot;
  end

  assign ld_grant_o = bus_req && dbus_i.gnt && !op_q.we;

  // context for the result stage, latched there on the grant
  always_comb
  begin
    ld_ctx_o.size        = op_q.size;
    ld_ctx_o.sign_ext    = op_q.sign_ext;
    ld_ctx_o.offset      = offset;
    ld_ctx_o.rd          = op_q.rd;
    ld_ctx_o.second_part = part_q;
    ld_ctx_o.last        = !split_q || part_q;
  end

endmodule

// File: src/lsu_result.sv
`timescale 1ns/1ns

module lsu_result
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ld_grant_i,
  input  lsu_pkg::ld_ctx_t    ld_ctx_i,
  input  dbus_pkg::dbus_rsp_t dbus_i,
  output lsu_pkg::lsu_res_t   result_o
);

  lsu_pkg::ld_ctx_t              ctx_q;
  logic                          ld_pend_q;  // rvalid still owed to a load part
  logic [dbus_pkg::DATA_W-1:0]   rdata_q;    // first word of a split load
  logic                          ld_rvalid;
  logic [2*dbus_pkg::DATA_W-1:0] pair;
  logic [2*dbus_pkg::DATA_W-1:0] shifted;
  logic [31:0]                   aligned;
  logic [31:0]                   ext;

  assign ld_rvalid = dbus_i.rvalid && ld_pend_q;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      ld_pend_q <= 1'b0;
    else if (ld_grant_i)
      ld_pend_q <= 1'b1;
    else if (dbus_i.rvalid)
      ld_pend_q <= 1'b0;                    // store rvalids leave it low
  end

  always_ff @(posedge clk)
  begin
    if (ld_grant_i)
      ctx_q <= ld_ctx_i;
    if (ld_rvalid && !ctx_q.last)
      rdata_q <= dbus_i.rdata;              // keep the low word
  end

  ////////////////////////////////////////////////////////////////////
  // alignment and extension
  ////////////////////////////////////////////////////////////////////

  // new word on top of the stored one for the second part
  assign pair    = ctx_q.second_part ? {dbus_i.rdata, rdata_q}
                                     : {{dbus_pkg::DATA_W{1'b0}}, dbus_i.rdata};
  assign shifted = pair >> {ctx_q.offset, 3'b000};
  assign aligned = shifted[31:0];           // addressed byte now in lane 0

  always_comb
  begin
    case (ctx_q.size)
      lsu_pkg::BYTE:
      begin
        if (ctx_q.sign_ext)
          ext = {{24{aligned[7]}}, aligned[7:0]};
        else
          ext = {24'h00_0000, aligned[7:0]};
      end
      lsu_pkg::HALF:
      begin
        if (ctx_q.sign_ext)
          ext = {{16{aligned[15]}}, aligned[15:0]};
        else
          ext = {16'h0000, aligned[15:0]};
      end
      default: ext = aligned;               // word
    endcase
  end

  // combinational on rdata, valid in the cycle of the last rvalid
  always_comb
  begin
    result_o.valid = ld_rvalid && ctx_q.last;
    result_o.rd    = ctx_q.rd;
    result_o.data  = ext;
  end

endmodule

// File: src/lsu_top.sv
`timescale 1ns/1ns

module lsu_top
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                valid_i,
  input  lsu_pkg::instr_u     instr_i,
  input  logic [31:0]         rs1_i,
  input  logic [31:0]         rs2_i,
  output logic                ready_o,
  output logic                illegal_o,
  output lsu_pkg::lsu_res_t   result_o,
  output dbus_pkg::dbus_req_t dbus_o,
  input  dbus_pkg::dbus_rsp_t dbus_i
);

  lsu_pkg::lsu_op_t op;
  logic             is_mem;
  lsu_pkg::ld_ctx_t ld_ctx;
  logic             ld_grant;

  ////////////////////////////////////////////////////////////////////
  // decode, execute, result
  ////////////////////////////////////////////////////////////////////

  lsu_decode u_decode
  (
    .instr_i  (instr_i),
    .op_o     (op),
    .is_mem_o (is_mem)
  );

  lsu_execute u_execute
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_i    (valid_i),
    .is_mem_i   (is_mem),
    .op_i       (op),
    .rs1_i      (rs1_i),
    .rs2_i      (rs2_i),
    .dbus_i     (dbus_i),
    .dbus_o     (dbus_o),
    .ready_o    (ready_o),
    .illegal_o  (illegal_o),
    .ld_ctx_o   (ld_ctx),
    .ld_grant_o (ld_grant)
  );

  lsu_result u_result
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .ld_grant_i (ld_grant),      // one pulse per granted load part
    .ld_ctx_i   (ld_ctx),
    .dbus_i     (dbus_i),
    .result_o   (result_o)
  );

endmodule

// File: tb/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen
(
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_NS = 5;  // 10 ns period

  initial
  begin
    clk_o = 1'b0;
    forever #HALF_NS clk_o = ~clk_o;
  end

  // reset held over three rising edges, let go on a falling one
  initial
  begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: tb/tb_dbus_mem.sv
`timescale 1ns/1ns

module tb_dbus_mem
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  dbus_pkg::dbus_req_t dbus_i,
  output dbus_pkg::dbus_rsp_t dbus_o
);

  logic [7:0]  mem [64];          // 16 words, upper address bits ignored
  integer      seed = 32'hc6da;
  logic [1:0]  delay_q;           // cycles left before the next grant
  logic        rvalid_q;
  logic [31:0] rdata_q;
  logic        gnt;

  initial
  begin
    for (int i = 0; i < 64; i++)
      mem[i] = 8'(i * 29 + 7);    // every address bit shows up in the byte
  end

  assign gnt = dbus_i.req && (delay_q == 2'd0);

  always @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      delay_q  <= 2'($random(seed));
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end
    else
    begin
      rvalid_q <= gnt;            // one rvalid per grant, a cycle later
      if (gnt)
      begin
        delay_q <= 2'($random(seed));  // 0 to 3 cycles for the next one
        for (int b = 0; b < 4; b++)
        begin
          rdata_q[8*b +: 8] <= mem[{dbus_i.addr[5:2], 2'(b)}];
          if (dbus_i.we && dbus_i.be[b])
            mem[{dbus_i.addr[5:2], 2'(b)}] = dbus_i.wdata[8*b +: 8];
        end
      end
      else if (dbus_i.req)
        delay_q <= delay_q - 2'd1;
    end
  end

  always_comb
  begin
    dbus_o.gnt    = gnt;
    dbus_o.rvalid = rvalid_q;
    dbus_o.rdata  = rdata_q;
  end

endmodule

// File: tb/lsu_tb.sv
`timescale 1ns/1ns

module lsu_tb;

  localparam int CLK_NS   = 10;
  // aligned 32, sub-word 32, misaligned 12, illegal 8
  localparam int N_INSTR  = 32 + 32 + 12 + 8;
  localparam int LIMIT_NS = (N_INSTR * 20 + 10) * CLK_NS;

  logic                clk;
  logic                rst_n;
  logic                valid;
  lsu_pkg::instr_u     instr;
  logic [31:0]         rs1;
  logic [31:0]         rs2;
  logic                ready;
  logic                illegal;
  lsu_pkg::lsu_res_t   result;
  dbus_pkg::dbus_req_t dbus_req;
  dbus_pkg::dbus_rsp_t dbus_rsp;

  integer              seed = 32'hc6da;
  string               test_name = "reset";
  logic [7:0]          shadow [64];    // expected memory contents

  // filled by the bus monitor
  logic [31:0]         grant_addr [$];
  lsu_pkg::lsu_res_t   results [$];
  int                  illegal_cnt = 0;
  int                  stall_cycles = 0;
  int                  reset_edges = 0;
  logic                first_after_reset = 1'b0;
  logic                req_q = 1'b0;
  logic                gnt_q = 1'b0;
  logic                rv_owed = 1'b0;  // grant seen and rvalid still owed
  dbus_pkg::dbus_req_t held_req;

  tb_clkgen u_clkgen
  (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  lsu_top u_dut
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_i   (valid),
    .instr_i   (instr),
    .rs1_i     (rs1),
    .rs2_i     (rs2),
    .ready_o   (ready),
    .illegal_o (illegal),
    .result_o  (result),
    .dbus_o    (dbus_req),
    .dbus_i    (dbus_rsp)
  );

  tb_dbus_mem u_mem
  (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .dbus_i  (dbus_req),
    .dbus_o  (dbus_rsp)
  );

  //////////////////////////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first failed check");
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("error %s %s expected %h actual %h", test_name, what, exp, act);
      abort_run();
    end
  endtask

  task automatic confirm(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("%s: %s", test_name, what);
      abort_run();
    end
  endtask

  // little endian load from the shadow bytes with ISA extension
  // funct3 bit 2 selects zero extension
  function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                input logic [2:0] f3);
    logic [31:0] raw;
    int          n;
    n   = 1 << f3[1:0];
    raw = '0;
    for (int i = 0; i < n; i++)
      raw[8*i +: 8] = shadow[6'(addr[5:0] + 6'(i))];
    if (!f3[2] && (n == 1))
      raw = {{24{raw[7]}}, raw[7:0]};
    else if (!f3[2] && (n == 2))
      raw = {{16{raw[15]}}, raw[15:0]};
    return raw;
  endfunction

  function automatic void store_shadow(input logic [31:0] addr, input logic [2:0] f3,
                                       input logic [31:0] data);
    int n;
    n = 1 << f3[1:0];
    for (int i = 0; i < n; i++)
      shadow[6'(addr[5:0] + 6'(i))] = data[8*i +: 8];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // bus monitor sampling at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (reset_edges > 0)  // first edge may precede the async reset
        confirm(!dbus_req.req && !result.valid && !illegal && ready,
                "outputs not idle during reset");
      reset_edges++;
      first_after_reset = 1'b1;
      req_q   = 1'b0;
      gnt_q   = 1'b0;
      rv_owed = 1'b0;
    end
    else
    begin
      if (first_after_reset)
        confirm(!dbus_req.req && !result.valid && !illegal && ready,
                "outputs not idle in the first cycle after reset");
      first_after_reset = 1'b0;
      // a waiting request holds all its fields
      if (req_q && !gnt_q)
        confirm(dbus_req.req && (dbus_req == held_req),
                "request changed while waiting for gnt");
      if (dbus_req.req && !dbus_rsp.gnt)
      begin
        confirm(!ready, "ready high while a request waits for gnt");
        stall_cycles++;
      end
      if (rv_owed)
        confirm(!dbus_req.req, "req raised before the rvalid of the last grant");
      if (dbus_req.req && dbus_rsp.gnt)
      begin
        grant_addr.push_back(dbus_req.addr);
        rv_owed = 1'b1;
      end
      else if (dbus_rsp.rvalid)
        rv_owed = 1'b0;
      if (result.valid)
        results.push_back(result);
      if (illegal)
        illegal_cnt++;
      req_q    = dbus_req.req;
      gnt_q    = dbus_rsp.gnt;
      held_req = dbus_req;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus driven on the falling edge
  //////////////////////////////////////////////////////////////////////

  // one accept cycle that returns at the following falling edge
  task automatic issue(input logic [31:0] word, input logic [31:0] a,
                       input logic [31:0] b);
    confirm(ready, "not ready for a new instruction");
    instr = word;
    rs1   = a;
    rs2   = b;
    valid = 1'b1;
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic issue_mem(input logic st, input logic [2:0] f3, input logic [5:0] loc,
                           input logic [31:0] data);
    logic [11:0] imm;
    logic [31:0] addr;
    logic [31:0] word;
    logic [4:0]  rd;
    logic        split;
    int          n_grant;
    int          n_res;
    int          n_illegal;
    addr = {26'($random(seed)), loc};   // model sees only the low six bits
    imm  = 12'($random(seed));
    rd   = 5'($random(seed));
    if (st)
      word = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], lsu_pkg::OPC_STORE};
    else
      word = {imm, 5'd1, f3, rd, lsu_pkg::OPC_LOAD};
    // access runs past the last byte of its word
    split = (int'(loc[1:0]) + (1 << f3[1:0])) > 4;
    n_grant   = grant_addr.size();
    n_res     = results.size();
    n_illegal = illegal_cnt;
    issue(word, addr - {{20{imm[11]}}, imm}, data);
    confirm(!ready, "ready stayed high after accept");
    while (!ready)
      @(negedge clk);
    compare_value("bus transactions", split ? 2 : 1, grant_addr.size() - n_grant);
    compare_value("first word address", {addr[31:2], 2'b00}, grant_addr[n_grant]);
    if (split)
      compare_value("second word address", {addr[31:2], 2'b00} + 32'd4,
                    grant_addr[n_grant + 1]);
    compare_value("illegal pulses", n_illegal, illegal_cnt);
    if (st)
    begin
      store_shadow(addr, f3, data);
      compare_value("results of a store", n_res, results.size());
    end
    else
    begin
      compare_value("results of a load", n_res + 1, results.size());
      compare_value("load rd", 32'(rd), 32'(results[n_res].rd));
      compare_value("load data", expected_load(addr, f3), results[n_res].data);
    end
  endtask

  task automatic issue_illegal(input logic [31:0] word);
    int n_grant;
    int n_illegal;
    n_grant   = grant_addr.size();
    n_illegal = illegal_cnt;
    issue(word, 32'($random(seed)), 32'($random(seed)));
    confirm(ready, "ready dropped after an illegal word");
    @(negedge clk);
    compare_value("illegal pulses", n_illegal + 1, illegal_cnt);
    compare_value("grants after an illegal word", n_grant, grant_addr.size());
    confirm(!dbus_req.req, "illegal word raised a request");
  endtask

  initial
  begin
    logic [5:0]  loc;
    logic [31:0] data;
    valid = 1'b0;
    instr = '0;
    rs1   = '0;
    rs2   = '0;
    @(posedge rst_n);
    repeat (2) @(negedge clk);

    // whole window written first so the shadow is complete
    test_name = "aligned";
    for (int w = 0; w < 16; w++)
      issue_mem(1'b1, 3'b010, 6'(w * 4), 32'($random(seed)));
    for (int k = 0; k < 8; k++)
    begin
      loc = {4'($random(seed)), 2'b00};
      issue_mem(1'b1, 3'b010, loc, 32'($random(seed)));  // sw
      issue_mem(1'b0, 3'b010, loc, 32'd0);               // lw
    end

    // odd offsets get a set sign bit and even ones a clear one
    test_name = "sub-word";
    for (int off = 0; off < 4; off++)
    begin
      loc     = {4'($random(seed)), 2'(off)};
      data    = 32'($random(seed));
      data[7] = off[0];
      issue_mem(1'b1, 3'b000, loc, data);                // sb
      issue_mem(1'b0, 3'b000, loc, 32'd0);               // lb
      issue_mem(1'b0, 3'b100, loc, 32'd0);               // lbu
      issue_mem(1'b0, 3'b010, {loc[5:2], 2'b00}, 32'd0); // neighbours kept
    end
    for (int off = 0; off < 4; off++)
    begin
      loc      = {4'($random(seed)), 2'(off)};
      data     = 32'($random(seed));
      data[15] = off[0];
      issue_mem(1'b1, 3'b001, loc, data);                // sh
      issue_mem(1'b0, 3'b001, loc, 32'd0);               // lh
      issue_mem(1'b0, 3'b101, loc, 32'd0);               // lhu
      issue_mem(1'b0, 3'b010, {loc[5:2], 2'b00}, 32'd0);
    end

    test_name = "misaligned";
    for (int off = 1; off < 4; off++)
    begin
      loc = {4'($random(seed)), 2'(off)};
      issue_mem(1'b1, 3'b010, loc, 32'($random(seed)));  // split sw
      issue_mem(1'b0, 3'b010, loc, 32'd0);               // split lw
      issue_mem(1'b0, 3'b010, {loc[5:2], 2'b00} + 6'd4, 32'd0);  // upper word
    end
    loc = {4'($random(seed)), 2'd3};                     // half across words
    issue_mem(1'b1, 3'b001, loc, 32'($random(seed)));
    issue_mem(1'b0, 3'b001, loc, 32'd0);
    issue_mem(1'b0, 3'b101, loc, 32'd0);

    test_name = "illegal";
    issue_illegal({25'($random(seed)), 7'b0110011});     // register alu op
    issue_illegal({25'($random(seed)), 7'b1101111});     // jal
    issue_illegal({17'($random(seed)), 3'd3, 5'd4, lsu_pkg::OPC_LOAD});
    issue_illegal({17'($random(seed)), 3'd6, 5'd4, lsu_pkg::OPC_LOAD});
    issue_illegal({17'($random(seed)), 3'd7, 5'd4, lsu_pkg::OPC_LOAD});
    issue_illegal({17'($random(seed)), 3'd3, 5'd4, lsu_pkg::OPC_STORE});
    issue_illegal({17'($random(seed)), 3'd4, 5'd4, lsu_pkg::OPC_STORE});
    issue_illegal({17'($random(seed)), 3'd5, 5'd4, lsu_pkg::OPC_STORE});

    // the hold checks in the monitor need at least one stalled request
    test_name = "back-pressure";
    confirm(stall_cycles > 0, "no request ever waited for its grant");

    $display("STATUS: PASS");
    $finish;
  end

  // watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("watchdog expired before the tests finished");
    abort_run();
  end

endmodule

// File: verilog.f
src/lsu_pkg.sv
src/dbus_pkg.sv
src/lsu_decode.sv
src/lsu_execute.sv
src/lsu_result.sv
src/lsu_top.sv
tb/tb_clkgen.sv
tb/tb_dbus_mem.sv
tb/lsu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile the lsu testbench with verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module lsu_tb -f verilog.f

# a failed check ends in $fatal, which gives a nonzero exit status
./obj_dir/Vlsu_tb
